/* src/i2c_bus_pkg.sv */
`default_nettype none

package i2c_bus_pkg;

    // Master sequence, one entry per bit slot on the wire.
    // DONE lasts one clk cycle and returns the result.
    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        START    = 4'd1,
        ADDR     = 4'd2,
        ADDR_ACK = 4'd3,
        DATA     = 4'd4,
        DATA_ACK = 4'd5,
        STOP     = 4'd6,
        DONE     = 4'd7
    } master_state_e;

    // Quarter index within one SCL bit.
    // SCL is low in quarters 0 and 1 and high in quarters 2 and 3.
    // SDA is set up in quarter 0 and sampled in quarter 2.
    typedef logic [1:0] phase_t;

endpackage

`default_nettype wire

/* src/xfer_pkg.sv */
`default_nettype none

package xfer_pkg;

    // Encoded so that the value is the R/W bit sent after the address.
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    // One single-byte transfer as issued by a requester.
    typedef struct packed {
        logic [6:0] addr;
        op_e        op;
        logic [7:0] wdata;
    } xfer_req_t;

    // Result of a transfer, valid with the done pulse.
    // rdata is zero for writes.
    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } xfer_rsp_t;

endpackage

`default_nettype wire

/* src/i2c_bit_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_timer #(
    parameter int CLK_DIV = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    output logic                tick,
    output i2c_bus_pkg::phase_t phase
);

    localparam int CW = $clog2(CLK_DIV);

    logic [CW-1:0] cnt;

    // Tick marks the last cycle of a quarter.
    assign tick = run && (cnt == CW'(CLK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Held at quarter 0 while idle so the first bit starts aligned.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (!run) begin
            phase <= '0;
        end else if (tick) begin
            phase <= phase + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  xfer_pkg::xfer_req_t cmd,
    input  logic                tick,
    input  i2c_bus_pkg::phase_t phase,
    output logic                run,
    output logic                busy,
    output logic                xfer_done,
    output xfer_pkg::xfer_rsp_t rsp,
    input  logic                sda_i,
    input  logic                scl_i,
    output logic                sda_o,
    output logic                scl_o
);

    i2c_bus_pkg::master_state_e state;
    logic [2:0]                 bit_cnt;
    logic                       nack;
    logic                       bit_edge;
    logic                       sda_bit;
    logic [7:0]                 shreg;
    logic [7:0]                 wdata_q;
    logic [7:0]                 rdata;
    xfer_pkg::op_e              op_q;

    assign busy      = (state != i2c_bus_pkg::IDLE);
    assign run       = busy && (state != i2c_bus_pkg::DONE);
    assign xfer_done = (state == i2c_bus_pkg::DONE);
    assign rsp.rdata = rdata;
    assign rsp.nack  = nack;

    // Level put on SDA at the start of each bit.
    // A NACKed address leaves the data phase released.
    always_comb begin
        case (state)
            i2c_bus_pkg::ADDR: sda_bit = shreg[7];
            i2c_bus_pkg::DATA: sda_bit = (op_q == xfer_pkg::OP_WRITE && !nack) ? shreg[7] : 1'b1;
            i2c_bus_pkg::STOP: sda_bit = 1'b0;
            default:           sda_bit = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= i2c_bus_pkg::IDLE;
            bit_cnt  <= '0;
            nack     <= 1'b0;
            bit_edge <= 1'b0;
            scl_o    <= 1'b1;
            sda_o    <= 1'b1;
        end else begin
            // SDA moves one cycle after SCL falls, still in quarter 0.
            bit_edge <= tick && (phase == 2'd3);
            if (state == i2c_bus_pkg::IDLE) begin
                if (start) begin
                    state <= i2c_bus_pkg::START;
                    nack  <= 1'b0;
                end
            end else if (state == i2c_bus_pkg::DONE) begin
                state <= i2c_bus_pkg::IDLE;
            end else if (tick) begin
                case (phase)
                    2'd1: begin
                        scl_o <= 1'b1;
                        if (state == i2c_bus_pkg::START) begin
                            sda_o <= 1'b0;
                        end
                    end
                    2'd2: begin
                        if (state == i2c_bus_pkg::STOP) begin
                            sda_o <= 1'b1;
                        end
                        if (state == i2c_bus_pkg::ADDR_ACK && sda_i) begin
                            nack <= 1'b1;
                        end
                        // On reads the second ack slot belongs to the master.
                        if (state == i2c_bus_pkg::DATA_ACK && op_q == xfer_pkg::OP_WRITE
                                && sda_i) begin
                            nack <= 1'b1;
                        end
                    end
                    2'd3: begin
                        scl_o <= (state == i2c_bus_pkg::STOP);
                        case (state)
                            i2c_bus_pkg::START: begin
                                state   <= i2c_bus_pkg::ADDR;
                                bit_cnt <= 3'd7;
                            end
                            i2c_bus_pkg::ADDR: begin
                                if (bit_cnt == 3'd0) begin
                                    state <= i2c_bus_pkg::ADDR_ACK;
                                end else begin
                                    bit_cnt <= bit_cnt - 1'b1;
                                end
                            end
                            i2c_bus_pkg::ADDR_ACK: begin
                                state   <= i2c_bus_pkg::DATA;
                                bit_cnt <= 3'd7;
                            end
                            i2c_bus_pkg::DATA: begin
                                if (bit_cnt == 3'd0) begin
                                    state <= i2c_bus_pkg::DATA_ACK;
                                end else begin
                                    bit_cnt <= bit_cnt - 1'b1;
                                end
                            end
                            i2c_bus_pkg::DATA_ACK: state <= i2c_bus_pkg::STOP;
                            i2c_bus_pkg::STOP:     state <= i2c_bus_pkg::DONE;
                            default:               state <= i2c_bus_pkg::IDLE;
                        endcase
                    end
                    default: ;
                endcase
            end else if (bit_edge) begin
                sda_o <= sda_bit;
            end
        end
    end

    // The address MSB goes out in the first ADDR bit, so START does not shift.
    always_ff @(posedge clk) begin
        if (start && state == i2c_bus_pkg::IDLE) begin
            shreg   <= {cmd.addr, cmd.op};
            op_q    <= cmd.op;
            wdata_q <= cmd.wdata;
            rdata   <= '0;
        end else if (tick && phase == 2'd3) begin
            if (state == i2c_bus_pkg::ADDR_ACK) begin
                shreg <= wdata_q;
            end else if (state != i2c_bus_pkg::START) begin
                shreg <= {shreg[6:0], 1'b0};
            end
        end else if (tick && phase == 2'd2 && state == i2c_bus_pkg::DATA
                && op_q == xfer_pkg::OP_READ) begin
            rdata <= {rdata[6:0], sda_i};
        end
    end

    // Idle bus must read back high, so nothing else holds SCL.
    a_idle_scl_high: assert property (@(posedge clk) disable iff (!rst_n)
        state == i2c_bus_pkg::IDLE |-> scl_o && scl_i);

    // Only START and STOP may move SDA while SCL is high.
    a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(sda_o) && !(state inside {i2c_bus_pkg::START, i2c_bus_pkg::STOP})
        |-> !scl_o && !$past(scl_o));

endmodule

`default_nettype wire

/* src/xfer_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module xfer_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_0,
    input  logic                req_1,
    input  xfer_pkg::xfer_req_t cmd_0,
    input  xfer_pkg::xfer_req_t cmd_1,
    input  logic                busy,
    input  logic                xfer_done,
    output logic                start,
    output xfer_pkg::xfer_req_t cmd,
    output logic                done_0,
    output logic                done_1
);

    logic       active;
    logic       last_gnt;
    logic [1:0] done_mask;
    logic       eff_0;
    logic       eff_1;
    logic       pick_1;
    logic       grant_now;

    // A requester may still hold req in the cycle after its done.
    assign eff_0     = req_0 && !done_mask[0];
    assign eff_1     = req_1 && !done_mask[1];
    assign pick_1    = eff_1 && (!eff_0 || !last_gnt);
    assign grant_now = !active && !busy && (eff_0 || eff_1);

    assign done_0 = xfer_done && active && !last_gnt;
    assign done_1 = xfer_done && active && last_gnt;

    // last_gnt starts at 1 so channel 0 wins the first tie.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            last_gnt  <= 1'b1;
            start     <= 1'b0;
            done_mask <= '0;
        end else begin
            start     <= 1'b0;
            done_mask <= {done_1, done_0};
            if (xfer_done) begin
                active <= 1'b0;
            end else if (grant_now) begin
                active   <= 1'b1;
                last_gnt <= pick_1;
                start    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_now) begin
            cmd <= pick_1 ? cmd_1 : cmd_0;
        end
    end

    // Every master done reaches exactly one channel.
    a_done_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_done |-> $onehot({done_0, done_1}));

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(start) |-> !busy);

endmodule

`default_nettype wire

/* src/i2c_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_subsys #(
    parameter int CLK_DIV = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_0,
    input  xfer_pkg::xfer_req_t cmd_0,
    output logic                done_0,
    output xfer_pkg::xfer_rsp_t rsp_0,
    input  logic                req_1,
    input  xfer_pkg::xfer_req_t cmd_1,
    output logic                done_1,
    output xfer_pkg::xfer_rsp_t rsp_1,
    input  logic                sda_i,
    input  logic                scl_i,
    output logic                sda_o,
    output logic                scl_o
);

    logic                start;
    logic                busy;
    logic                xfer_done;
    logic                run;
    logic                tick;
    i2c_bus_pkg::phase_t phase;
    xfer_pkg::xfer_req_t cmd;
    xfer_pkg::xfer_rsp_t rsp;

    // Both channels see the result; only the granted one gets done.
    assign rsp_0 = rsp;
    assign rsp_1 = rsp;

    xfer_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_0     (req_0),
        .req_1     (req_1),
        .cmd_0     (cmd_0),
        .cmd_1     (cmd_1),
        .busy      (busy),
        .xfer_done (xfer_done),
        .start     (start),
        .cmd       (cmd),
        .done_0    (done_0),
        .done_1    (done_1)
    );

    i2c_bit_timer #(
        .CLK_DIV (CLK_DIV)
    ) u_bit_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .tick  (tick),
        .phase (phase)
    );

    i2c_master u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cmd       (cmd),
        .tick      (tick),
        .phase     (phase),
        .run       (run),
        .busy      (busy),
        .xfer_done (xfer_done),
        .rsp       (rsp),
        .sda_i     (sda_i),
        .scl_i     (scl_i),
        .sda_o     (sda_o),
        .scl_o     (scl_o)
    );

endmodule

`default_nettype wire

/* dv/i2c_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_0,
    input  logic                req_1,
    input  logic                done_0,
    input  logic                done_1,
    input  xfer_pkg::xfer_rsp_t rsp_0,
    input  xfer_pkg::xfer_rsp_t rsp_1,
    input  logic                sda,
    input  logic                scl,
    input  int                  test_num,
    input  logic [1:0]          test_mask,
    input  logic                first_ch,
    input  xfer_pkg::xfer_rsp_t exp_0,
    input  xfer_pkg::xfer_rsp_t exp_1
);

    int errors = 0;
    int tests = 0;
    int starts = 0;
    int stops = 0;
    int dones = 0;
    int cur_test = -1;
    int seen = 0;
    int test_errs = 0;

    // START and STOP are SDA edges while SCL is high.
    always @(negedge sda) begin
        if (rst_n && scl === 1'b1) begin
            starts++;
        end
    end

    always @(posedge sda) begin
        if (rst_n && scl === 1'b1) begin
            stops++;
        end
    end

    task automatic compare_rsp(input string name, input xfer_pkg::xfer_rsp_t exp,
                               input xfer_pkg::xfer_rsp_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_high(input string name, input logic value);
        if (value !== 1'b1) begin
            $display("** Error at %0t: %s expected 1, got %b", $time, name, value);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (test_num != cur_test) begin
            cur_test  = test_num;
            seen      = 0;
            test_errs = 0;
        end
        // With no request pending the bus must rest high.
        if (rst_n && !req_0 && !req_1) begin
            check_high("sda", sda);
            check_high("scl", scl);
        end
        if (done_0 || done_1) begin
            dones++;
            if (seen >= $countones(test_mask)) begin
                $display("Unexpected done pulse at %0t in test %0d", $time, cur_test);
                errors++;
            end else begin
                if (seen == 0 && test_mask == 2'b11 && done_1 !== first_ch) begin
                    $display("Test %0d: channel %0d was served first, expected channel %0d",
                             cur_test, done_1, first_ch);
                    test_errs++;
                end
                if (done_0) begin
                    compare_rsp("rsp_0", exp_0, rsp_0);
                end
                if (done_1) begin
                    compare_rsp("rsp_1", exp_1, rsp_1);
                end
                seen++;
                if (seen == $countones(test_mask)) begin
                    tests++;
                    errors += test_errs;
                    $display("Test %0d (mask %b): %0d error(s)", cur_test, test_mask,
                             test_errs);
                end
            end
        end
    end

    task automatic finish_report(output int total);
        if (starts != dones) begin
            $display("Saw %0d START conditions but %0d done pulses", starts, dones);
            errors++;
        end
        if (stops != dones) begin
            $display("Saw %0d STOP conditions but %0d done pulses", stops, dones);
            errors++;
        end
        $display("Tests: %0d, errors: %0d, START: %0d, STOP: %0d, done: %0d",
                 tests, errors, starts, stops, dones);
        total = errors;
    endtask

endmodule

`default_nettype wire

/* dv/tb_i2c_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_subsys;

    localparam int         CLK_DIV     = 4;
    localparam int         ROWS        = 6;
    localparam int         LIMIT       = ROWS * 2 * (21 * 4 * CLK_DIV + 20);
    localparam logic [6:0] TARGET_ADDR = 7'h2A;

    typedef struct packed {
        logic [1:0]          mask;
        logic                first_ch;
        xfer_pkg::xfer_req_t cmd_0;
        xfer_pkg::xfer_req_t cmd_1;
        xfer_pkg::xfer_rsp_t exp_0;
        xfer_pkg::xfer_rsp_t exp_1;
    } test_row_t;

    logic                clk;
    logic                rst_n;
    logic                req_0;
    logic                req_1;
    xfer_pkg::xfer_req_t cmd_0;
    xfer_pkg::xfer_req_t cmd_1;
    logic                done_0;
    logic                done_1;
    xfer_pkg::xfer_rsp_t rsp_0;
    xfer_pkg::xfer_rsp_t rsp_1;
    logic                sda_o;
    logic                scl_o;
    logic                sda;
    logic                scl;
    test_row_t           table_q [ROWS];
    test_row_t           row;
    int                  test_num;
    int                  cycles = 0;
    int                  total_errors;
    logic [15:0]         lfsr;
    logic [7:0]          model_reg;
    // The target releases SDA while target_sda is high.
    logic                target_sda;
    logic [7:0]          target_reg;
    logic [7:0]          target_shift;
    int                  target_bit;
    logic                target_sel;
    logic                target_rd;

    // Open-drain SDA is the AND of both drivers.
    // The target never stretches SCL.
    assign sda = sda_o & target_sda;
    assign scl = scl_o;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    i2c_subsys #(
        .CLK_DIV (CLK_DIV)
    ) dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_0  (req_0),
        .cmd_0  (cmd_0),
        .done_0 (done_0),
        .rsp_0  (rsp_0),
        .req_1  (req_1),
        .cmd_1  (cmd_1),
        .done_1 (done_1),
        .rsp_1  (rsp_1),
        .sda_i  (sda),
        .scl_i  (scl),
        .sda_o  (sda_o),
        .scl_o  (scl_o)
    );

    i2c_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_0     (req_0),
        .req_1     (req_1),
        .done_0    (done_0),
        .done_1    (done_1),
        .rsp_0     (rsp_0),
        .rsp_1     (rsp_1),
        .sda       (sda),
        .scl       (scl),
        .test_num  (test_num),
        .test_mask (row.mask),
        .first_ch  (row.first_ch),
        .exp_0     (row.exp_0),
        .exp_1     (row.exp_1)
    );

    // Target at TARGET_ADDR. Bit 8 is the address ack, 9 to 16 data, 17 the data ack.
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            target_bit = -1;
            target_sel = 1'b0;
        end
    end

    always @(posedge scl) begin
        target_shift = {target_shift[6:0], sda};
    end

    always @(negedge scl) begin
        target_bit++;
        target_sda = 1'b1;
        if (target_bit == 8 && target_shift[7:1] == TARGET_ADDR) begin
            target_sel = 1'b1;
            target_rd  = target_shift[0];
            target_sda = 1'b0;
        end else if (target_sel && target_rd && target_bit >= 9 && target_bit <= 16) begin
            target_sda = target_reg[16 - target_bit];
        end else if (target_sel && !target_rd && target_bit == 17) begin
            target_reg = target_shift;
            target_sda = 1'b0;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    function automatic xfer_pkg::xfer_req_t make_cmd(input logic [6:0] addr,
                                                     input xfer_pkg::op_e op);
        xfer_pkg::xfer_req_t c;
        c.addr  = addr;
        c.op    = op;
        c.wdata = (op == xfer_pkg::OP_WRITE) ? random_byte() : 8'h00;
        return c;
    endfunction

    // Follows the target's register rule in transfer order.
    function automatic xfer_pkg::xfer_rsp_t predict_rsp(input xfer_pkg::xfer_req_t c);
        xfer_pkg::xfer_rsp_t r;
        r = '0;
        if (c.addr != TARGET_ADDR) begin
            r.nack = 1'b1;
        end else if (c.op == xfer_pkg::OP_WRITE) begin
            model_reg = c.wdata;
        end else begin
            r.rdata = model_reg;
        end
        return r;
    endfunction

    task automatic add_row(input int idx, input logic [1:0] mask, input logic first_ch,
                           input xfer_pkg::xfer_req_t c0, input xfer_pkg::xfer_req_t c1);
        test_row_t r;
        r          = '0;
        r.mask     = mask;
        r.first_ch = first_ch;
        r.cmd_0    = c0;
        r.cmd_1    = c1;
        if (mask == 2'b11 && first_ch) begin
            r.exp_1 = predict_rsp(c1);
            r.exp_0 = predict_rsp(c0);
        end else begin
            if (mask[0]) r.exp_0 = predict_rsp(c0);
            if (mask[1]) r.exp_1 = predict_rsp(c1);
        end
        table_q[idx] = r;
    endtask

    task automatic build_table();
        add_row(0, 2'b11, 1'b0, make_cmd(TARGET_ADDR, xfer_pkg::OP_WRITE),
                make_cmd(TARGET_ADDR, xfer_pkg::OP_READ));
        add_row(1, 2'b01, 1'b0, make_cmd(7'h35, xfer_pkg::OP_WRITE), '0);
        add_row(2, 2'b10, 1'b0, '0, make_cmd(TARGET_ADDR, xfer_pkg::OP_READ));
        add_row(3, 2'b01, 1'b0, make_cmd(TARGET_ADDR, xfer_pkg::OP_WRITE), '0);
        // Channel 0 went last, so channel 1 wins this tie.
        add_row(4, 2'b11, 1'b1, make_cmd(TARGET_ADDR, xfer_pkg::OP_WRITE),
                make_cmd(TARGET_ADDR, xfer_pkg::OP_READ));
        add_row(5, 2'b10, 1'b0, '0, make_cmd(TARGET_ADDR, xfer_pkg::OP_READ));
    endtask

    // Requests start two cycles after the last done so both channels are eligible.
    task automatic run_row(input int idx);
        logic [1:0] pending;
        repeat (2) @(negedge clk);
        row      = table_q[idx];
        test_num = idx;
        cmd_0    = row.cmd_0;
        cmd_1    = row.cmd_1;
        req_0    = row.mask[0];
        req_1    = row.mask[1];
        pending  = row.mask;
        while (pending != 2'b00) begin
            @(negedge clk);
            if (done_0) begin
                req_0      = 1'b0;
                pending[0] = 1'b0;
            end
            if (done_1) begin
                req_1      = 1'b0;
                pending[1] = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        req_0      = 1'b0;
        req_1      = 1'b0;
        cmd_0      = '0;
        cmd_1      = '0;
        row        = '0;
        test_num   = -1;
        target_sda = 1'b1;
        target_reg = 8'h00;
        target_bit = 100;
        target_sel = 1'b0;
        target_rd  = 1'b0;
        model_reg  = 8'h00;
        lfsr       = 16'd12;
        build_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            run_row(i);
        end
        repeat (4) @(negedge clk);
        u_checker.finish_report(total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/i2c_bus_pkg.sv
src/xfer_pkg.sv
src/i2c_bit_timer.sv
src/i2c_master.sv
src/xfer_arbiter.sv
src/i2c_subsys.sv
dv/i2c_checker.sv
dv/tb_i2c_subsys.sv

/* Makefile */
TOP := tb_i2c_subsys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
